// ==== Bender.yml ====
package:
  name: dmac_read_addr

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dmac_xfer_pkg.sv
      - rtl/dmac_axi_pkg.sv
      - rtl/dmac_reg_slice.sv
      - rtl/dmac_burst_splitter.sv
      - rtl/dmac_address_generator.sv
      - rtl/dmac_read_addr_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_dmac_read_addr.sv

// ==== all.f ====
+incdir+rtl
rtl/dmac_xfer_pkg.sv
rtl/dmac_axi_pkg.sv
rtl/dmac_reg_slice.sv
rtl/dmac_burst_splitter.sv
rtl/dmac_address_generator.sv
rtl/dmac_read_addr_top.sv
test/tb_dmac_read_addr.sv

// ==== rtl/dmac_address_generator.sv ====
/*
 * Issues one AXI read address beat per burst counted by the splitter.
 * A beat goes out whenever id trails request_id while enable and
 * enabled are high. Dropping enable only takes effect once a pending
 * beat is accepted. A request taken while disabled waits for enable.
 */
`timescale 1ns/10ps
`default_nettype none

`include "dmac_cfg.svh"

module dmac_address_generator (
  input  logic                      clk,
  input  logic                      resetn,

  input  logic                      req_valid,
  output logic                      req_ready,
  input  dmac_xfer_pkg::burst_req_t req,

  output dmac_xfer_pkg::req_id_t    id,
  input  dmac_xfer_pkg::req_id_t    request_id,
  input  logic                      eot,

  input  logic                      enable,
  output logic                      enabled,

  output logic                      addr_valid,
  input  logic                      addr_ready,
  output dmac_axi_pkg::axi_addr_t   addr
);

  localparam int ADDR_W    = `DMAC_ADDR_WIDTH;
  localparam int BPB_W     = `DMAC_BYTES_PER_BEAT_WIDTH;
  localparam int BURST_W   = `DMAC_BEATS_PER_BURST_WIDTH;
  localparam int LEN_W     = `DMAC_LENGTH_WIDTH;
  localparam int MAX_BEATS = 2 ** BURST_W;
  localparam int SIZE_LOG2 = $clog2(`DMAC_DATA_WIDTH / 8);

  logic [ADDR_W-BPB_W-1:0] address;
  logic [BURST_W-1:0]      last_burst_len;
  logic [LEN_W-1:0]        length;
  logic                    last;
  logic                    addr_valid_d1;
  logic                    req_take;
  logic                    beat_take;

  assign req_take  = req_ready & req_valid;
  assign beat_take = ~req_ready & addr_valid & addr_ready;

  // ******************************
  // Enable handshake
  // ******************************

  // A beat already on the bus has to be accepted before turning off
  always_ff @(posedge clk) begin
    if (!resetn) begin
      enabled <= 1'b0;
    end else if (enable) begin
      enabled <= 1'b1;
    end else if (!addr_valid) begin
      enabled <= 1'b0;
    end
  end

  // ******************************
  // Burst length selection
  // ******************************

  // eot is only sampled between beats, it refers to the next burst
  always_ff @(posedge clk) begin
    if (!addr_valid) begin
      length <= eot ? LEN_W'(last_burst_len) : LEN_W'(MAX_BEATS - 1);
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      last <= 1'b0;
    end else if (!addr_valid) begin
      last <= eot;
    end
  end

  // Request and beat handshakes
  // A latched request stays until its last beat, even across a disable
  always_ff @(posedge clk) begin
    if (!resetn) begin
      req_ready  <= 1'b1;
      addr_valid <= 1'b0;
    end else if (req_ready) begin
      if (req_valid) begin
        req_ready <= 1'b0;
      end
    end else if (addr_valid && addr_ready) begin
      addr_valid <= 1'b0;
      // The final burst frees the generator for the next request
      if (last) begin
        req_ready <= 1'b1;
      end
    end else if (id != request_id && enable && enabled) begin
      addr_valid <= 1'b1;
    end
  end

  // Address of the current burst, steps one full burst per beat
  always_ff @(posedge clk) begin
    if (req_take) begin
      address        <= req.beat_addr;
      last_burst_len <= req.last_burst_len;
    end else if (beat_take) begin
      address <= address + (ADDR_W - BPB_W)'(MAX_BEATS);
    end
  end

  // id follows request_id, one step per issued beat
  // Stepping on the rising edge keeps the splitter's limit conservative
  always_ff @(posedge clk) begin
    if (!resetn) begin
      id            <= '0;
      addr_valid_d1 <= 1'b0;
    end else begin
      addr_valid_d1 <= addr_valid;
      if (addr_valid && !addr_valid_d1) begin
        id <= dmac_xfer_pkg::inc_id(id);
      end
    end
  end

  // AR beat, fixed fields from the AXI package
  assign addr.addr  = {address, {BPB_W{1'b0}}};
  assign addr.len   = length;
  assign addr.size  = 3'(SIZE_LOG2);
  assign addr.burst = dmac_axi_pkg::BURST_INCR;
  assign addr.prot  = dmac_axi_pkg::PROT_DEFAULT;
  assign addr.cache = dmac_axi_pkg::CACHE_DEFAULT;

endmodule

`default_nettype wire

// ==== rtl/dmac_axi_pkg.sv ====
/*
 * AXI read address beat as issued by the DMA read path.
 * Bursts are always INCR with unprivileged, secure data access and a
 * bufferable, modifiable cache setting. No user or QoS fields exist.
 */
`default_nettype none

`include "dmac_cfg.svh"

package dmac_axi_pkg;

  // ******************************
  // Address channel payload
  // ******************************

  // One AR beat, field order follows the AXI signal list
  typedef struct packed {
    logic [`DMAC_ADDR_WIDTH-1:0]   addr;
    logic [`DMAC_LENGTH_WIDTH-1:0] len;
    logic [2:0]                    size;
    logic [1:0]                    burst;
    logic [2:0]                    prot;
    logic [3:0]                    cache;
  } axi_addr_t;

  // ******************************
  // Fixed encodings
  // ******************************

  // Incrementing burst
  localparam logic [1:0] BURST_INCR = 2'b01;
  // Unprivileged, secure, data access
  localparam logic [2:0] PROT_DEFAULT = 3'b000;
  // Bufferable and modifiable
  localparam logic [3:0] CACHE_DEFAULT = 4'b0011;

endpackage

`default_nettype wire

// ==== rtl/dmac_burst_splitter.sv ====
/*
 * Splits a transfer into fixed-size bursts for the address generator.
 * One request ID step is made per burst, at most one per cycle.
 * Never more than 2**DMAC_ID_WIDTH - 1 bursts run ahead of id.
 * A new transfer is only taken once all bursts of the last one have
 * been addressed.
 */
`timescale 1ns/10ps
`default_nettype none

`include "dmac_cfg.svh"

module dmac_burst_splitter (
  input  logic                     clk,
  input  logic                     resetn,

  input  logic                     xfer_valid,
  output logic                     xfer_ready,
  input  dmac_xfer_pkg::xfer_req_t xfer,

  output logic                     req_valid,
  input  logic                     req_ready,
  output dmac_xfer_pkg::burst_req_t req,

  output dmac_xfer_pkg::req_id_t   request_id,
  input  dmac_xfer_pkg::req_id_t   id,
  output logic                     eot
);

  localparam int ADDR_W  = `DMAC_ADDR_WIDTH;
  localparam int BPB_W   = `DMAC_BYTES_PER_BEAT_WIDTH;
  localparam int BURST_W = `DMAC_BEATS_PER_BURST_WIDTH;
  localparam int XFER_W  = `DMAC_XFER_BEATS_WIDTH;
  // One more bit than the burst index, as the count runs to 2**index
  localparam int CNT_W   = XFER_W - BURST_W + 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_COUNT
  } state_t;

  state_t                  state;
  logic [CNT_W-1:0]        bursts_left;
  dmac_xfer_pkg::req_id_t  final_id;
  logic                    final_valid;
  dmac_xfer_pkg::req_id_t  next_request_id;
  logic                    id_limit;
  logic                    xfer_take;

  assign xfer_take       = xfer_valid & xfer_ready;
  assign next_request_id = dmac_xfer_pkg::inc_id(request_id);

  // One more step would make request_id catch up with id from behind,
  // which reads as zero bursts outstanding
  assign id_limit = (next_request_id == id);

  // The burst after id closes the transfer
  // final_valid keeps a stale final_id from matching mid-transfer
  assign eot = final_valid & (dmac_xfer_pkg::inc_id(id) == final_id);

  // ******************************
  // Control FSM
  // ******************************
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state       <= ST_IDLE;
      xfer_ready  <= 1'b0;
      req_valid   <= 1'b0;
      request_id  <= '0;
      final_id    <= '0;
      final_valid <= 1'b0;
      bursts_left <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (xfer_take) begin
            xfer_ready  <= 1'b0;
            req_valid   <= 1'b1;
            final_valid <= 1'b0;
            bursts_left <= CNT_W'(xfer.beats_minus_one[XFER_W-1:BURST_W]) + 1'b1;
            state       <= ST_REQUEST;
          end else begin
            // Wait for the generator to drain the previous transfer
            xfer_ready <= (id == final_id) & req_ready;
          end
        end
        ST_REQUEST: begin
          if (req_ready) begin
            req_valid <= 1'b0;
            state     <= ST_COUNT;
          end
        end
        default: begin
          if (!id_limit) begin
            request_id  <= next_request_id;
            bursts_left <= bursts_left - 1'b1;
            if (bursts_left == CNT_W'(1)) begin
              final_id    <= next_request_id;
              final_valid <= 1'b1;
              state       <= ST_IDLE;
            end
          end
        end
      endcase
    end
  end

  // Burst request payload, loaded with the transfer
  always_ff @(posedge clk) begin
    if (xfer_take) begin
      req.beat_addr      <= xfer.start_addr[ADDR_W-1:BPB_W];
      req.last_burst_len <= xfer.beats_minus_one[BURST_W-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dmac_cfg.svh ====
/*
 * Widths and burst geometry of the DMA read address path.
 * All start addresses must be aligned to a full burst, as no 4 KiB
 * boundary check exists. Address bits below one beat are dropped.
 * DMAC_ID_WIDTH bounds the outstanding bursts to 2**DMAC_ID_WIDTH - 1.
 */
`ifndef DMAC_CFG_SVH
`define DMAC_CFG_SVH

// ******************************
// Bus geometry
// ******************************

// Byte address width on the memory side
`define DMAC_ADDR_WIDTH 32
// Data bus width in bits, one beat per transfer
`define DMAC_DATA_WIDTH 64
// Address bits covered by a single beat, log2 of the bytes per beat
`define DMAC_BYTES_PER_BEAT_WIDTH 3
// Log2 of the beats in a full burst
`define DMAC_BEATS_PER_BURST_WIDTH 4
// Width of the AXI len field
`define DMAC_LENGTH_WIDTH 8

// ******************************
// Request tracking
// ******************************

// Request ID width, Gray coded
`define DMAC_ID_WIDTH 3
// Transfer length in beats minus one
`define DMAC_XFER_BEATS_WIDTH 12

`endif

// ==== rtl/dmac_read_addr_top.sv ====
/*
 * Read address half of the DMA memory interface.
 * A transfer enters through a register slice, is split into bursts and
 * leaves as AR beats through a second slice. Transfers are served in
 * order and one at a time.
 */
`timescale 1ns/10ps
`default_nettype none

module dmac_read_addr_top (
  input  logic                      clk,
  input  logic                      resetn,

  input  logic                      xfer_valid,
  output logic                      xfer_ready,
  input  dmac_xfer_pkg::xfer_req_t  xfer,

  input  logic                      enable,
  output logic                      enabled,

  output logic                      ar_valid,
  input  logic                      ar_ready,
  output dmac_axi_pkg::axi_addr_t   ar
);

  // Transfer after the input slice
  logic                      xfer_s_valid;
  logic                      xfer_s_ready;
  dmac_xfer_pkg::xfer_req_t  xfer_s;

  // Splitter to generator
  logic                      req_valid;
  logic                      req_ready;
  dmac_xfer_pkg::burst_req_t req;
  dmac_xfer_pkg::req_id_t    request_id;
  dmac_xfer_pkg::req_id_t    id;
  logic                      eot;

  // Generator to output slice
  logic                      addr_valid;
  logic                      addr_ready;
  dmac_axi_pkg::axi_addr_t   addr;

  // ******************************
  // Transfer input
  // ******************************
  dmac_reg_slice #(
    .payload_t(dmac_xfer_pkg::xfer_req_t)
  ) xfer_slice_inst (
    .clk      (clk),
    .resetn   (resetn),
    .in_valid (xfer_valid),
    .in_ready (xfer_ready),
    .in_data  (xfer),
    .out_valid(xfer_s_valid),
    .out_ready(xfer_s_ready),
    .out_data (xfer_s)
  );

  dmac_burst_splitter burst_splitter_inst (
    .clk       (clk),
    .resetn    (resetn),
    .xfer_valid(xfer_s_valid),
    .xfer_ready(xfer_s_ready),
    .xfer      (xfer_s),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .request_id(request_id),
    .id        (id),
    .eot       (eot)
  );

  // ******************************
  // Address output
  // ******************************
  dmac_address_generator address_generator_inst (
    .clk       (clk),
    .resetn    (resetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .id        (id),
    .request_id(request_id),
    .eot       (eot),
    .enable    (enable),
    .enabled   (enabled),
    .addr_valid(addr_valid),
    .addr_ready(addr_ready),
    .addr      (addr)
  );

  dmac_reg_slice #(
    .payload_t(dmac_axi_pkg::axi_addr_t)
  ) ar_slice_inst (
    .clk      (clk),
    .resetn   (resetn),
    .in_valid (addr_valid),
    .in_ready (addr_ready),
    .in_data  (addr),
    .out_valid(ar_valid),
    .out_ready(ar_ready),
    .out_data (ar)
  );

endmodule

`default_nettype wire

// ==== rtl/dmac_reg_slice.sv ====
/*
 * One-entry valid/ready register stage for any payload type.
 * in_ready still depends on out_ready through a gate, so only the
 * data and valid paths are cut by a register here.
 */
`timescale 1ns/10ps
`default_nettype none

module dmac_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     resetn,

  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,

  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;
  logic     take;

  // Room exists when empty or when the held beat leaves this cycle
  assign in_ready = ~full | out_ready;
  assign take     = in_valid & in_ready;

  assign out_valid = full;
  assign out_data  = data_q;

  // Occupancy of the single entry
  always_ff @(posedge clk) begin
    if (!resetn) begin
      full <= 1'b0;
    end else if (take) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  // The payload only loads on an accepted beat
  // It is held unchanged while full and stalled
  always_ff @(posedge clk) begin
    if (take) begin
      data_q <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dmac_xfer_pkg.sv ====
/*
 * Transfer side types of the DMA read address path.
 * The request ID counts in Gray code, so it can be compared across a
 * clock domain crossing without a multi-bit glitch.
 */
`default_nettype none

`include "dmac_cfg.svh"

package dmac_xfer_pkg;

  // A transfer as the DMA core hands it in
  typedef struct packed {
    logic [`DMAC_ADDR_WIDTH-1:0]       start_addr;
    logic [`DMAC_XFER_BEATS_WIDTH-1:0] beats_minus_one;
  } xfer_req_t;

  // Burst request towards the address generator
  // The beat address drops the bits below one beat
  typedef struct packed {
    logic [`DMAC_ADDR_WIDTH-`DMAC_BYTES_PER_BEAT_WIDTH-1:0] beat_addr;
    logic [`DMAC_BEATS_PER_BURST_WIDTH-1:0]                last_burst_len;
  } burst_req_t;

  typedef logic [`DMAC_ID_WIDTH-1:0] req_id_t;

  // Next value in the Gray sequence
  // Decodes to binary, adds one and encodes again
  function automatic req_id_t inc_id(input req_id_t id);
    req_id_t bin;
    req_id_t nxt;
    bin[`DMAC_ID_WIDTH-1] = id[`DMAC_ID_WIDTH-1];
    for (int i = `DMAC_ID_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ id[i];
    end
    nxt = bin + 1'b1;
    return nxt ^ (nxt >> 1);
  endfunction

endpackage

`default_nettype wire

// ==== test/tb_dmac_read_addr.sv ====
/*
 * Self-checking testbench for the DMA read address path.
 * Stimulus comes from an xorshift generator with a fixed seed, and every
 * AR beat is compared with a queue model built from each sent transfer.
 * Enable is only dropped while no transfer is in flight.
 */
`timescale 1ns/10ps
`default_nettype none

`include "dmac_cfg.svh"

module tb_dmac_read_addr;

  localparam int BEATS_PER_BURST = 1 << `DMAC_BEATS_PER_BURST_WIDTH;
  localparam int BURST_BYTES     = BEATS_PER_BURST << `DMAC_BYTES_PER_BEAT_WIDTH;
  localparam int XFER_TIMEOUT    = 6000;
  localparam int DRAIN_TIMEOUT   = 30000;
  localparam int ENABLE_TIMEOUT  = 20;

  logic                     clk;
  logic                     resetn;
  logic                     xfer_valid;
  logic                     xfer_ready;
  dmac_xfer_pkg::xfer_req_t xfer;
  logic                     enable;
  logic                     enabled;
  logic                     ar_valid;
  logic                     ar_ready;
  dmac_axi_pkg::axi_addr_t  ar;

  dmac_axi_pkg::axi_addr_t  expected_q[$];
  int                       ready_mode;
  int                       stall_left;
  logic [31:0]              stim_rng;
  logic [31:0]              ready_rng;
  string                    test_name;

  dmac_read_addr_top dmac_read_addr_top_inst (
    .clk       (clk),
    .resetn    (resetn),
    .xfer_valid(xfer_valid),
    .xfer_ready(xfer_ready),
    .xfer      (xfer),
    .enable    (enable),
    .enabled   (enabled),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar        (ar)
  );

  always #10 clk = ~clk;

  // ******************************
  // Helpers
  // ******************************

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "Simulation stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
      abort_run("A checked value did not match the model");
    end
  endtask

  // Expands a transfer into its AR beats, one per burst
  task automatic add_expected(input dmac_xfer_pkg::xfer_req_t t);
    dmac_axi_pkg::axi_addr_t beat;
    int                      bursts;
    logic [31:0]             base;
    bursts = int'(t.beats_minus_one) / BEATS_PER_BURST + 1;
    base   = t.start_addr & ~((32'd1 << `DMAC_BYTES_PER_BEAT_WIDTH) - 1);
    for (int k = 0; k < bursts; k++) begin
      beat.addr  = base + 32'(k * BURST_BYTES);
      // Only the final burst is shortened
      beat.len   = (k == bursts - 1) ? 8'(t.beats_minus_one % BEATS_PER_BURST) :
                                       8'(BEATS_PER_BURST - 1);
      beat.size  = 3'(`DMAC_BYTES_PER_BEAT_WIDTH);
      beat.burst = dmac_axi_pkg::BURST_INCR;
      beat.prot  = dmac_axi_pkg::PROT_DEFAULT;
      beat.cache = dmac_axi_pkg::CACHE_DEFAULT;
      expected_q.push_back(beat);
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  // Mode changes land between falling edges so the ready driver sees them cleanly
  task automatic set_ready_mode(input int mode);
    @(posedge clk);
    ready_mode = mode;
    @(negedge clk);
  endtask

  // Start addresses stay burst aligned, apart from random bits below one beat
  task automatic send_xfer(input logic [11:0] n);
    dmac_xfer_pkg::xfer_req_t t;
    int                       waited;
    logic                     accepted;
    stim_rng          = xorshift(stim_rng);
    t.start_addr      = {stim_rng[31:7], 4'b0000, stim_rng[2:0]};
    t.beats_minus_one = n;
    xfer              = t;
    xfer_valid        = 1'b1;
    waited            = 0;
    accepted          = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = xfer_ready;
      @(negedge clk);
      if (!accepted) begin
        waited++;
        if (waited > XFER_TIMEOUT) begin
          abort_run($sformatf("%s: transfer was not accepted in time", test_name));
        end
      end
    end
    add_expected(t);
    xfer_valid = 1'b0;
    xfer       = '0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        abort_run($sformatf("%s: expected AR beats did not all arrive", test_name));
      end
    end
  endtask

  task automatic wait_enabled(input logic value);
    int waited;
    waited = 0;
    while (enabled !== value) begin
      @(negedge clk);
      waited++;
      if (waited > ENABLE_TIMEOUT) begin
        abort_run($sformatf("%s: enabled did not reach %0b in time", test_name, value));
      end
    end
  endtask

  // ******************************
  // AR ready driver
  // ******************************

  // Mode 0 always ready, mode 1 random, mode 2 random with long stalls
  always @(negedge clk) begin
    ready_rng = xorshift(ready_rng);
    if (ready_mode == 0) begin
      ar_ready = 1'b1;
    end else if (ready_mode == 1) begin
      ar_ready = ready_rng[0] | ready_rng[1];
    end else if (stall_left > 0) begin
      stall_left--;
      ar_ready = 1'b0;
    end else if (ready_rng[7:0] < 8'd12) begin
      stall_left = 10 + int'(ready_rng[13:8]);
      ar_ready   = 1'b0;
    end else begin
      ar_ready = ready_rng[9];
    end
  end

  // ******************************
  // Collector
  // ******************************
  always @(posedge clk) begin
    dmac_axi_pkg::axi_addr_t exp_beat;
    if (resetn && ar_valid && ar_ready) begin
      if (expected_q.size() == 0) begin
        abort_run($sformatf("%s: an AR beat arrived that the model did not expect",
                            test_name));
      end else begin
        exp_beat = expected_q.pop_front();
        check_value({test_name, " addr"}, exp_beat.addr, ar.addr);
        check_value({test_name, " len"}, exp_beat.len, ar.len);
        check_value({test_name, " size"}, exp_beat.size, ar.size);
        check_value({test_name, " burst"}, exp_beat.burst, ar.burst);
        check_value({test_name, " prot"}, exp_beat.prot, ar.prot);
        check_value({test_name, " cache"}, exp_beat.cache, ar.cache);
      end
    end
  end

  // ******************************
  // Test sequence
  // ******************************
  initial begin
    clk            = 1'b0;
    resetn         = 1'b0;
    xfer_valid     = 1'b0;
    xfer           = '0;
    enable         = 1'b0;
    ar_ready       = 1'b0;
    ready_mode     = 0;
    stall_left     = 0;
    stim_rng       = 32'd37954;
    ready_rng      = xorshift(32'd37954);
    test_name      = "reset";

    repeat (3) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    check_value("reset enabled", 0, enabled);
    check_value("reset ar_valid", 0, ar_valid);
    enable = 1'b1;
    wait_enabled(1'b1);

    // Transfers of one burst each, drained one by one
    test_name = "single";
    for (int i = 0; i < 12; i++) begin
      stim_rng = xorshift(stim_rng);
      send_xfer(12'(stim_rng[3:0]));
      wait_drained();
      idle(2);
    end

    // Up to 16 bursts per transfer with the bus always ready
    test_name = "multi";
    for (int i = 0; i < 10; i++) begin
      stim_rng = xorshift(stim_rng);
      send_xfer(12'(stim_rng[7:0]));
      wait_drained();
    end

    // Long AR stalls fill the output slice and hit the ID limit
    test_name = "backpressure";
    set_ready_mode(2);
    for (int i = 0; i < 12; i++) begin
      stim_rng = xorshift(stim_rng);
      send_xfer(12'(stim_rng[7:0]));
      idle(int'(stim_rng[9:8]));
    end
    wait_drained();

    test_name = "back_to_back";
    set_ready_mode(1);
    for (int i = 0; i < 20; i++) begin
      stim_rng = xorshift(stim_rng);
      send_xfer(12'(stim_rng[5:0]));
      idle(int'(stim_rng[11:10]));
    end
    wait_drained();

    // A transfer queued while disabled must wait, then come out whole
    test_name = "enable";
    set_ready_mode(0);
    idle(5);
    enable = 1'b0;
    wait_enabled(1'b0);
    send_xfer(12'd40);
    for (int i = 0; i < 30; i++) begin
      @(negedge clk);
      check_value("enable_off ar_valid", 0, ar_valid);
    end
    enable = 1'b1;
    wait_enabled(1'b1);
    wait_drained();

    idle(20);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
